// File: sim/fog_axis_tests.txt
// Vector count first, then one vector per line, all values hex
// freq wait amp_hi amp_lo avg offset pol fb const_step g_step g_ramp adc_hi adc_lo exp_err strobes
9
// Modulation levels only, zero step
0008 0002 1000 0800 0 00000000 0 0 00000000 00 00 2100 1f00 00000c00 4
// Inverted polarity with an offset
000a 0003 2000 1800 0 00000100 1 0 00000000 00 00 2040 1fc0 fffffd80 3
// Negative difference and a negative offset
0006 0002 0c00 0400 0 ffffff00 0 0 00000000 00 00 2010 2030 00000080 3
// Four period average
0005 0002 3000 2000 2 00000000 0 0 00000000 00 00 2200 2000 00000600 3
// Eight period average at full scale, inverted
0004 0002 0100 0000 3 00000010 1 0 00000000 00 00 3fff 0000 ffff8012 2
// Open loop ramp, positive step
0008 0002 4000 3000 0 00000000 0 0 00012345 00 04 2000 2000 00000000 6
// Open loop ramp, negative step, two period average
0006 0003 8000 7000 1 00000000 0 0 fff00000 00 08 2000 2000 00000000 5
// Closed loop, positive error
0008 0002 1000 0f00 0 00000000 0 1 00000000 03 02 2100 2000 00000600 6
// Closed loop, negative error, two period average
0006 0002 2000 1000 1 00000000 0 1 00000000 02 00 1f80 2000 fffffe00 5

// File: project.f
hw/fog_pkg.sv
hw/fog_mod_if.sv
hw/fog_mod_gen.sv
hw/fog_err_demod.sv
hw/fog_feedback.sv
hw/fog_axis_top.sv
sim/fog_axis_properties.sv
sim/fog_axis_tb.sv

// File: Makefile
# Verilator build and run of the single axis FOG loop

VERILATOR ?= verilator
TOP       ?= fog_axis_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
EXTRA     ?=

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: sim/fog_axis_tb.sv
`default_nettype none

module fog_axis_tb import fog_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int VEC_WORDS  = 15;     // Columns per vector line
	localparam int MAX_VECS   = 12;
	localparam int HALF_PER   = 50;     // 100 ns clock
	localparam int SKEW       = 1;      // Input drive after the edge
	localparam int RST_CYCLES = 5;

	logic     CLOCK_DAC;
	logic     locked_0;
	adc_t     adc;
	cnt_t     freq_cnt;
	cnt_t     wait_cnt;
	dac_t     amp_hi;
	dac_t     amp_lo;
	avg_sel_t avg_sel;
	data_t    err_offset;
	logic     polarity;
	logic     fb_on;
	data_t    const_step;
	shift_t   gain_step;
	shift_t   gain_ramp;
	dac_t     dac;
	logic     sync;
	data_t    err;
	logic     err_valid;
	data_t    step;

	logic [31:0] vec_mem [0:VEC_WORDS*MAX_VECS];     // Word 0 is the vector count

	// Levels and expectations of the running vector
	adc_t  adc_hi;
	adc_t  adc_lo;
	data_t exp_err;
	int    n_strobes;

	// Reference state for the current cycle
	int    pos;             // Cycle in the period, 0 is first high cycle
	int    periods;         // Closed periods since reset
	int    avg_len;
	int    syncs_since;
	int    strobes;
	logic  exp_sync;
	logic  exp_valid;
	data_t model_err;
	data_t model_step;
	data_t model_ramp;

	fog_axis_top fog_axis_top_inst (
		.CLOCK_DAC    (CLOCK_DAC),
		.locked_0     (locked_0),
		.i_adc        (adc),
		.i_freq_cnt   (freq_cnt),
		.i_amp_hi     (amp_hi),
		.i_amp_lo     (amp_lo),
		.i_wait_cnt   (wait_cnt),
		.i_avg_sel    (avg_sel),
		.i_err_offset (err_offset),
		.i_polarity   (polarity),
		.i_fb_on      (fb_on),
		.i_const_step (const_step),
		.i_gain_step  (gain_step),
		.i_gain_ramp  (gain_ramp),
		.o_dac        (dac),
		.o_sync       (sync),
		.o_err        (err),
		.o_err_valid  (err_valid),
		.o_step       (step)
	);

	// Pulse and hold rules watched inside the top level
	bind fog_axis_top fog_axis_properties #(
		.CNT_W(CNT_W)
	) fog_axis_properties_inst (
		.CLOCK_DAC   (CLOCK_DAC),
		.locked_0    (locked_0),
		.i_freq_cnt  (i_freq_cnt),
		.i_sync      (o_sync),
		.i_err       (o_err),
		.i_err_valid (o_err_valid)
	);

	initial begin
		CLOCK_DAC = 1'b0;
		forever #HALF_PER CLOCK_DAC = ~CLOCK_DAC;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp) begin
			abort_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_dac(input string name, input dac_t got, input dac_t exp);
		if (got !== exp) begin
			abort_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			abort_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	// Configuration columns onto the DUT inputs
	task automatic load_vector(input int v);
		int b;
		b          = 1 + v * VEC_WORDS;
		freq_cnt   = cnt_t'(vec_mem[b]);
		wait_cnt   = cnt_t'(vec_mem[b+1]);
		amp_hi     = dac_t'(vec_mem[b+2]);
		amp_lo     = dac_t'(vec_mem[b+3]);
		avg_sel    = avg_sel_t'(vec_mem[b+4]);
		err_offset = data_t'(vec_mem[b+5]);
		polarity   = vec_mem[b+6][0];
		fb_on      = vec_mem[b+7][0];
		const_step = data_t'(vec_mem[b+8]);
		gain_step  = shift_t'(vec_mem[b+9]);
		gain_ramp  = shift_t'(vec_mem[b+10]);
		adc_hi     = adc_t'(vec_mem[b+11]);
		adc_lo     = adc_t'(vec_mem[b+12]);
		exp_err    = data_t'(vec_mem[b+13]);
		n_strobes  = int'(vec_mem[b+14]);
		if (wait_cnt < 2 || wait_cnt >= freq_cnt) begin
			abort_run($sformatf("Vector %0d has an unusable wait count", v));
		end
	endtask

	task automatic reset_and_start(input int v);
		locked_0 = 1'b0;
		repeat (RST_CYCLES) begin
			@(posedge CLOCK_DAC);
			#SKEW;
		end
		load_vector(v);
		pos         = 0;        // First high half starts now
		periods     = 0;
		avg_len     = 1 << int'(avg_sel);
		syncs_since = 0;
		strobes     = 0;
		exp_sync    = 1'b0;
		exp_valid   = 1'b0;
		model_err   = '0;
		model_step  = '0;
		model_ramp  = '0;
		adc         = adc_hi;
		locked_0    = 1'b1;
	endtask

	// One clock before predicting and comparing every output
	task automatic advance_cycle();
		data_t step_old;
		data_t ramp_old;
		logic  hi_old;
		logic  valid_old;
		dac_t  exp_dac;
		step_old  = model_step;
		ramp_old  = model_ramp;
		hi_old    = (pos < int'(freq_cnt));
		valid_old = exp_valid;
		@(posedge CLOCK_DAC);
		#SKEW;
		pos       = (pos + 1) % (2 * int'(freq_cnt));
		exp_sync  = (pos == 1);         // Sync trails period start by one
		exp_valid = 1'b0;
		if (pos == 0) begin             // Low half just closed
			periods++;
			exp_valid = (periods % avg_len == 0);
		end
		if (valid_old) begin
			model_step = fb_on ? model_step + (exp_err >>> gain_step) : const_step;
		end
		if (exp_sync) begin
			model_ramp = ramp_old + step_old;   // Old step at period start
		end
		if (exp_valid) begin
			model_err = exp_err;
		end
		exp_dac = dac_t'(ramp_old >>> gain_ramp) + (hi_old ? amp_hi : amp_lo);
		check_bit("o_sync", sync, exp_sync);
		check_bit("o_err_valid", err_valid, exp_valid);
		check_data("o_err", err, model_err);
		check_data("o_step", step, model_step);
		check_dac("o_dac", dac, exp_dac);
		if (sync) begin
			syncs_since++;      // Trigger pulses seen from the DUT
		end
		if (err_valid) begin
			check_data("syncs per strobe", data_t'(syncs_since), data_t'(avg_len));
			syncs_since = 0;
			strobes++;
		end
		if (fog_axis_top_inst.fog_axis_properties_inst.assert_fails != 0) begin
			abort_run("An assertion on the top level outputs failed");
		end
		adc = (pos < int'(freq_cnt)) ? adc_hi : adc_lo;    // Sampled at next edge
	endtask

	task automatic run_vector(input int v);
		int limit;
		int cycles;
		reset_and_start(v);
		limit  = (n_strobes + 2) * 2 * int'(freq_cnt) * avg_len + 50;
		cycles = 0;
		while (strobes < n_strobes) begin
			advance_cycle();
			cycles++;
			if (cycles > limit) begin
				abort_run($sformatf("Timeout in vector %0d, %0d of %0d error strobes seen",
					v, strobes, n_strobes));
			end
		end
		$display("Vector %0d done in %0d cycles", v, cycles);
	endtask

	initial begin
		int n_vecs;
		locked_0    = 1'b0;
		adc         = '0;
		freq_cnt    = cnt_t'(8);
		wait_cnt    = cnt_t'(2);
		amp_hi      = '0;
		amp_lo      = '0;
		avg_sel     = '0;
		err_offset  = '0;
		polarity    = 1'b0;
		fb_on       = 1'b0;
		const_step  = '0;
		gain_step   = '0;
		gain_ramp   = '0;
		$readmemh("sim/fog_axis_tests.txt", vec_mem);
		if ($isunknown(vec_mem[0])) begin
			abort_run("Vector file is missing or empty");
		end
		n_vecs = int'(vec_mem[0]);
		if (n_vecs < 1 || n_vecs > MAX_VECS) begin
			abort_run($sformatf("Vector count %0d out of range", n_vecs));
		end
		for (int v = 0; v < n_vecs; v++) begin
			run_vector(v);
		end
		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim/fog_axis_properties.sv
`default_nettype none

module fog_axis_properties import fog_pkg::*; #(
	parameter int CNT_W = fog_pkg::CNT_W
) (
	input logic             CLOCK_DAC,
	input logic             locked_0,
	input logic [CNT_W-1:0] i_freq_cnt,     // Cycles per half
	input logic             i_sync,
	input data_t            i_err,
	input logic             i_err_valid
);

	timeunit 1ns;
	timeprecision 1ps;

	logic [CNT_W:0] since_sync;     // Cycles since the last sync
	logic           sync_seen;
	int             assert_fails = 0;   // Number of failed checks

	always_ff @(posedge CLOCK_DAC or negedge locked_0) begin
		if (!locked_0) begin
			since_sync <= '0;
			sync_seen  <= 1'b0;
		end
		else if (i_sync) begin
			since_sync <= (CNT_W+1)'(1);
			sync_seen  <= 1'b1;
		end
		else begin
			since_sync <= since_sync + (CNT_W+1)'(1);
		end
	end

	sync_pulse: assert property (@(posedge CLOCK_DAC) disable iff (!locked_0)
		i_sync |=> !i_sync)
		else begin
			assert_fails++;
			$error("o_sync high for more than one cycle");
		end

	valid_pulse: assert property (@(posedge CLOCK_DAC) disable iff (!locked_0)
		i_err_valid |=> !i_err_valid)
		else begin
			assert_fails++;
			$error("o_err_valid high for more than one cycle");
		end

	// Error word only moves with its strobe
	err_hold: assert property (@(posedge CLOCK_DAC) disable iff (!locked_0)
		!i_err_valid |-> $stable(i_err))
		else begin
			assert_fails++;
			$error("o_err changed without a strobe");
		end

	sync_period: assert property (@(posedge CLOCK_DAC) disable iff (!locked_0)
		(i_sync && sync_seen) |-> (since_sync == {i_freq_cnt, 1'b0}))
		else begin
			assert_fails++;
			$error("o_sync spacing differs from two half periods");
		end

endmodule

`default_nettype wire

// File: hw/fog_axis_top.sv
`default_nettype none

module fog_axis_top import fog_pkg::*; #(
	parameter int CNT_W = fog_pkg::CNT_W     // Modulation counter width
) (
	input  logic             CLOCK_DAC,
	input  logic             locked_0,         // PLL lock used as active low reset
	input  adc_t             i_adc,            // Detector ADC bus

	// Modulation
	input  logic [CNT_W-1:0] i_freq_cnt,       // Cycles per half period
	input  dac_t             i_amp_hi,
	input  dac_t             i_amp_lo,

	// Error generation
	input  logic [CNT_W-1:0] i_wait_cnt,       // Settling cycles per half
	input  avg_sel_t         i_avg_sel,
	input  data_t            i_err_offset,
	input  logic             i_polarity,

	// Feedback
	input  logic             i_fb_on,
	input  data_t            i_const_step,
	input  shift_t           i_gain_step,
	input  shift_t           i_gain_ramp,

	output dac_t             o_dac,            // Phase modulator drive
	output logic             o_sync,           // Period trigger
	output data_t            o_err,            // Rate error
	output logic             o_err_valid,
	output data_t            o_step            // Rate readout
);

	// Modulation timing shared by all three blocks
	fog_mod_if mod_if ();

	fog_mod_gen #(
		.CNT_W(CNT_W)
	) fog_mod_gen_inst (
		.CLOCK_DAC  (CLOCK_DAC),
		.locked_0   (locked_0),
		.i_freq_cnt (i_freq_cnt),
		.i_wait_cnt (i_wait_cnt),
		.i_amp_hi   (i_amp_hi),
		.i_amp_lo   (i_amp_lo),
		.m          (mod_if),
		.o_sync     (o_sync)
	);

	fog_err_demod fog_err_demod_inst (
		.CLOCK_DAC    (CLOCK_DAC),
		.locked_0     (locked_0),
		.i_adc        (i_adc),
		.i_avg_sel    (i_avg_sel),
		.i_err_offset (i_err_offset),
		.i_polarity   (i_polarity),
		.m            (mod_if),
		.o_err        (o_err),
		.o_err_valid  (o_err_valid)
	);

	// Error goes straight on to the step register
	fog_feedback fog_feedback_inst (
		.CLOCK_DAC    (CLOCK_DAC),
		.locked_0     (locked_0),
		.i_err        (o_err),
		.i_err_valid  (o_err_valid),
		.i_fb_on      (i_fb_on),
		.i_const_step (i_const_step),
		.i_gain_step  (i_gain_step),
		.i_gain_ramp  (i_gain_ramp),
		.m            (mod_if),
		.o_step       (o_step),
		.o_dac        (o_dac)
	);

endmodule

`default_nettype wire

// File: hw/fog_feedback.sv
`default_nettype none

module fog_feedback import fog_pkg::*; (
	input  logic  CLOCK_DAC,
	input  logic  locked_0,         // Active low async reset
	input  data_t i_err,            // Demodulated error
	input  logic  i_err_valid,      // New error this cycle
	input  logic  i_fb_on,          // Closed loop when set
	input  data_t i_const_step,     // Open loop step
	input  shift_t i_gain_step,     // Error to step gain, right shift
	input  shift_t i_gain_ramp,     // Ramp to DAC gain, right shift
	fog_mod_if.fb m,
	output data_t o_step,           // Ramp increment per period
	output dac_t  o_dac             // Word to the phase modulator DAC
);

	data_t err_scaled;      // Error after the step gain
	data_t ramp;            // Phase ramp wrapping in DATA_W bits
	data_t ramp_shift;      // Ramp after the DAC gain

	assign err_scaled = i_err >>> i_gain_step;     // Keep the sign
	assign ramp_shift = ramp >>> i_gain_ramp;

	// Step register
	always_ff @(posedge CLOCK_DAC or negedge locked_0) begin
		if (!locked_0) begin
			o_step <= '0;
		end
		else if (i_err_valid) begin
			if (i_fb_on) begin
				o_step <= o_step + err_scaled;     // Integrate the error
			end
			else begin
				o_step <= i_const_step;            // Fixed ramp rate
			end
		end
	end

	// Phase ramp takes one step per modulation period
	always_ff @(posedge CLOCK_DAC or negedge locked_0) begin
		if (!locked_0) begin
			ramp <= '0;
		end
		else if (m.period_start) begin
			ramp <= ramp + o_step;     // Natural wrap is the 2 pi reset
		end
	end

	// DAC word is ramp plus square wave modulo 2^DAC_W
	always_ff @(posedge CLOCK_DAC) begin
		o_dac <= ramp_shift[DAC_W-1:0] + m.mod_level;
	end

endmodule

`default_nettype wire

// File: hw/fog_err_demod.sv
`default_nettype none

module fog_err_demod import fog_pkg::*; (
	input  logic     CLOCK_DAC,
	input  logic     locked_0,         // Active low async reset
	input  adc_t     i_adc,            // Raw sample, offset binary
	input  avg_sel_t i_avg_sel,        // Average over 2^avg_sel periods
	input  data_t    i_err_offset,     // Removed after averaging
	input  logic     i_polarity,       // Invert the error sign
	fog_mod_if.demod m,
	output data_t    o_err,            // Held between strobes
	output logic     o_err_valid       // One cycle per averaging block
);

	// Period counter wide enough for 2^(2^AVG_W - 1) periods
	localparam int PCNT_W = (1 << AVG_W) - 1;

	logic signed [ADC_W-1:0] sample_s;      // Two's complement sample
	data_t                   sample_ext;
	data_t                   term;          // Signed contribution of this cycle
	data_t                   diff_acc;      // High minus low within the period
	data_t                   diff_next;
	data_t                   avg_sum;       // Sum of closed period differences
	data_t                   sum_next;
	data_t                   sum_shift;
	data_t                   err_offs;
	data_t                   err_next;
	logic [PCNT_W-1:0]       per_cnt;       // Closed periods in this block
	logic [PCNT_W:0]         avg_len;       // Periods per block
	logic                    period_end;
	logic                    avg_done;

	// Offset binary to signed by flipping the MSB
	assign sample_s   = {~i_adc[ADC_W-1], i_adc[ADC_W-2:0]};
	assign sample_ext = {{(DATA_W-ADC_W){sample_s[ADC_W-1]}}, sample_s};

	// Add in the high half, subtract in the low half, skip settling cycles
	always_comb begin
		if (!m.in_window) begin
			term = '0;
		end
		else if (m.half_hi) begin
			term = sample_ext;
		end
		else begin
			term = -sample_ext;
		end
	end

	assign diff_next = diff_acc + term;     // Includes the current cycle
	assign sum_next  = avg_sum + diff_next;

	// A period closes on the last cycle of its low half
	assign period_end = m.half_last && !m.half_hi;

	assign avg_len  = (PCNT_W+1)'(1) << i_avg_sel;
	assign avg_done = period_end && ({1'b0, per_cnt} == (avg_len - (PCNT_W+1)'(1)));

	// Mean over the block, then offset and sign
	assign sum_shift = sum_next >>> i_avg_sel;
	assign err_offs  = sum_shift - i_err_offset;
	assign err_next  = i_polarity ? -err_offs : err_offs;

	always_ff @(posedge CLOCK_DAC or negedge locked_0) begin
		if (!locked_0) begin
			diff_acc    <= '0;
			avg_sum     <= '0;
			per_cnt     <= '0;
			o_err       <= '0;
			o_err_valid <= 1'b0;
		end
		else begin
			o_err_valid <= avg_done;    // Strobe lands one cycle after half_last
			if (period_end) begin
				diff_acc <= '0;         // Fresh period
				if (avg_done) begin
					avg_sum <= '0;
					per_cnt <= '0;
					o_err   <= err_next;
				end
				else begin
					avg_sum <= sum_next;
					per_cnt <= per_cnt + PCNT_W'(1);
				end
			end
			else begin
				diff_acc <= diff_next;
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/fog_mod_gen.sv
`default_nettype none

module fog_mod_gen import fog_pkg::*; #(
	parameter int CNT_W = fog_pkg::CNT_W     // Counter width of 4 or more
) (
	input  logic             CLOCK_DAC,
	input  logic             locked_0,      // Active low async reset
	input  logic [CNT_W-1:0] i_freq_cnt,    // Cycles per half period
	input  logic [CNT_W-1:0] i_wait_cnt,    // Settling cycles at start of each half
	input  dac_t             i_amp_hi,      // Level of the high half
	input  dac_t             i_amp_lo,      // Level of the low half
	fog_mod_if.gen           m,
	output logic             o_sync         // Period start trigger for the board
);

	logic [CNT_W-1:0] half_cnt;     // Position within the half
	logic             half_hi;      // Which half we are in
	logic             half_last;
	logic             period_start;

	// Wrap point of the half counter
	assign half_last = (half_cnt == (i_freq_cnt - CNT_W'(1)));

	// First cycle of a high half
	assign period_start = half_hi && (half_cnt == '0);

	// Half counter and square wave
	always_ff @(posedge CLOCK_DAC or negedge locked_0) begin
		if (!locked_0) begin
			half_cnt <= '0;
			half_hi  <= 1'b1;       // High half starts right out of reset
		end
		else if (half_last) begin
			half_cnt <= '0;
			half_hi  <= ~half_hi;   // Toggle at each wrap
		end
		else begin
			half_cnt <= half_cnt + CNT_W'(1);
		end
	end

	// Exported trigger one cycle behind the internal period start
	always_ff @(posedge CLOCK_DAC or negedge locked_0) begin
		if (!locked_0) begin
			o_sync <= 1'b0;
		end
		else begin
			o_sync <= period_start;
		end
	end

	assign m.half_hi      = half_hi;
	assign m.half_last    = half_last;
	assign m.period_start = period_start;

	// Samples count only after the optics have settled
	assign m.in_window = (half_cnt >= i_wait_cnt);

	// Square wave amplitude
	assign m.mod_level = half_hi ? i_amp_hi : i_amp_lo;

endmodule

`default_nettype wire

// File: hw/fog_mod_if.sv
`default_nettype none

// Modulation timing from one generator to two readers
interface fog_mod_if import fog_pkg::*; ();

	logic half_hi;          // High half of the square wave
	logic in_window;        // Past the settling wait
	logic half_last;        // Last cycle of a half
	logic period_start;     // First cycle of a high half
	dac_t mod_level;        // Current modulation amplitude

	modport gen (
		output half_hi,
		output in_window,
		output half_last,
		output period_start,
		output mod_level
	);

	// Demodulator only needs the half and window timing
	modport demod (
		input half_hi,
		input in_window,
		input half_last
	);

	// Feedback steps the ramp per period and adds the level
	modport fb (
		input period_start,
		input mod_level
	);

endinterface

`default_nettype wire

// File: hw/fog_pkg.sv
`default_nettype none

package fog_pkg;

	// Converter and datapath widths
	localparam int ADC_W   = 14;    // Raw ADC bus
	localparam int DAC_W   = 16;    // DAC bus
	localparam int DATA_W  = 32;    // Error, step, offset, ramp
	localparam int CNT_W   = 16;    // Half period and wait count
	localparam int AVG_W   = 3;     // Averaging select for up to 2^7 periods
	localparam int SHIFT_W = 5;     // Gain selects for shifts of 0..31

	// Raw ADC sample in offset binary straight from the converter
	typedef logic [ADC_W-1:0] adc_t;

	// Unsigned DAC word
	typedef logic [DAC_W-1:0] dac_t;

	// Signed loop word
	typedef logic signed [DATA_W-1:0] data_t;

	// Cycle counts
	typedef logic [CNT_W-1:0] cnt_t;

	// Number of averaged periods is 2^avg_sel
	typedef logic [AVG_W-1:0] avg_sel_t;

	// Arithmetic right shift amount
	typedef logic [SHIFT_W-1:0] shift_t;

endpackage

`default_nettype wire
